/* l1i_pkg.sv */
package l1i_pkg;

  // ********************
  // Cache geometry.
  // ********************

  localparam int XLEN        = 32;
  localparam int INDEX_BITS  = 4;
  // Fixed at one bit, since every refill is exactly two words.
  localparam int OFFSET_BITS = 1;
  localparam int BYTE_BITS   = 2;
  localparam int TAG_BITS    = XLEN - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

  localparam int NUM_LINES   = 2 ** INDEX_BITS;
  localparam int LINE_WORDS  = 2 ** OFFSET_BITS;

  // ********************
  // Vector types.
  // ********************

  typedef logic [XLEN-1:0]       addr_t;
  typedef logic [XLEN-1:0]       word_t;
  typedef logic [15:0]           half_t;
  typedef logic [TAG_BITS-1:0]   tag_t;
  typedef logic [INDEX_BITS-1:0] index_t;

  // ********************
  // Refill FSM states.
  // ********************

  typedef enum logic [2:0] {
    idle     = 3'b000,
    rd_0     = 3'b001,
    wait_gap = 3'b010,
    rd_1     = 3'b011
  } fill_state_t;

endpackage

/* l1i_fill_if.sv */
`timescale 1ns/1ns

interface l1i_fill_if import l1i_pkg::*; ();

  // Lookup results from the line array.
  logic hit;
  logic hit_next;

  // Refill control from the FSM.
  addr_t                  fill_addr;
  logic                   fill_write;
  logic [OFFSET_BITS-1:0] fill_word_sel;
  logic                   fill_done;
  logic                   flush;

  modport ctrl (
    input  hit,
    input  hit_next,
    output fill_addr,
    output fill_write,
    output fill_word_sel,
    output fill_done,
    output flush
  );

  modport array (
    output hit,
    output hit_next,
    input  fill_addr,
    input  fill_write,
    input  fill_word_sel,
    input  fill_done,
    input  flush
  );

endinterface

/* l1i_fill_ctrl.sv */
`timescale 1ns/1ns

module l1i_fill_ctrl import l1i_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  addr_t    pc,
  input  logic     invalidate,
  input  logic     rvalid,
  output addr_t    araddr,
  output logic     arvalid,
  output logic     busy_flush,
  l1i_fill_if.ctrl fill
);

  fill_state_t state;
  addr_t       fill_addr_q;
  addr_t       pc_next;
  logic        flush_pending;
  logic        flush_req;
  logic        need_fill;

  assign pc_next   = pc + addr_t'(2);
  assign flush_req = invalidate || flush_pending;

  // Refill the line of pc first, then the line of pc plus 2.
  assign need_fill = !(fill.hit && fill.hit_next);

  // ********************
  // Refill FSM.
  // ********************

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (!flush_req && need_fill) begin
            state <= rd_0;
          end
        end
        rd_0: begin
          if (rvalid) begin
            state <= wait_gap;
          end
        end
        wait_gap: begin
          state <= rd_1;
        end
        rd_1: begin
          if (rvalid) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Only taken on the idle to rd_0 transition.
  always_ff @(posedge clock) begin
    if (state == idle) begin
      fill_addr_q <= fill.hit ? pc_next : pc;
    end
  end

  // An invalidate during a refill waits here until the FSM is idle again.
  always_ff @(posedge clock) begin
    if (reset) begin
      flush_pending <= 1'b0;
    end else if (state == idle) begin
      flush_pending <= 1'b0;
    end else if (invalidate) begin
      flush_pending <= 1'b1;
    end
  end

  // ********************
  // Bus and array control.
  // ********************

  assign arvalid    = (state == rd_0) || (state == rd_1);
  assign busy_flush = flush_req;

  assign fill.fill_addr     = fill_addr_q;
  assign fill.fill_write    = arvalid;
  assign fill.fill_word_sel = (state == rd_1);
  assign fill.fill_done     = (state == rd_1) && rvalid;
  assign fill.flush         = (state == idle) && flush_req;

  assign araddr = {fill_addr_q[XLEN-1:OFFSET_BITS+BYTE_BITS], fill.fill_word_sel,
                   {BYTE_BITS{1'b0}}};

  // Memory answers only while a read is outstanding.
  assert property (@(posedge clock) disable iff (reset)
    (state == idle || state == wait_gap) |-> !rvalid)
    else $error("rvalid seen with no read outstanding");

  // An invalidate during a refill is held until the FSM is idle.
  assert property (@(posedge clock) disable iff (reset)
    (state != idle && invalidate) |=> busy_flush)
    else $error("invalidate during refill was not held");

endmodule

/* l1i_line_array.sv */
`timescale 1ns/1ns

module l1i_line_array import l1i_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  addr_t     pc,
  input  word_t     rdata,
  input  logic      rvalid,
  output word_t     word_lo,
  output word_t     word_next,
  l1i_fill_if.array fill
);

  word_t                  data_mem [NUM_LINES][LINE_WORDS];
  tag_t                   tag_mem [NUM_LINES];
  logic [NUM_LINES-1:0]   valid_q;

  addr_t                  pc_next;
  tag_t                   pc_tag;
  index_t                 pc_index;
  logic [OFFSET_BITS-1:0] pc_word;
  tag_t                   nx_tag;
  index_t                 nx_index;
  logic [OFFSET_BITS-1:0] nx_word;
  tag_t                   fill_tag;
  index_t                 fill_index;
  logic                   word_write;

  // ********************
  // Address split.
  // ********************

  assign pc_next = pc + addr_t'(2);

  assign pc_tag   = pc[XLEN-1 -: TAG_BITS];
  assign pc_index = pc[BYTE_BITS+OFFSET_BITS +: INDEX_BITS];
  assign pc_word  = pc[BYTE_BITS +: OFFSET_BITS];

  assign nx_tag   = pc_next[XLEN-1 -: TAG_BITS];
  assign nx_index = pc_next[BYTE_BITS+OFFSET_BITS +: INDEX_BITS];
  assign nx_word  = pc_next[BYTE_BITS +: OFFSET_BITS];

  assign fill_tag   = fill.fill_addr[XLEN-1 -: TAG_BITS];
  assign fill_index = fill.fill_addr[BYTE_BITS+OFFSET_BITS +: INDEX_BITS];

  // ********************
  // Lookup.
  // ********************

  assign fill.hit      = valid_q[pc_index] && (tag_mem[pc_index] == pc_tag);
  assign fill.hit_next = valid_q[nx_index] && (tag_mem[nx_index] == nx_tag);

  assign word_lo   = data_mem[pc_index][pc_word];
  assign word_next = data_mem[nx_index][nx_word];

  // ********************
  // Refill writes.
  // ********************

  assign word_write = rvalid && fill.fill_write;

  always_ff @(posedge clock) begin
    if (word_write) begin
      data_mem[fill_index][fill.fill_word_sel] <= rdata;
    end
    if (fill.fill_done) begin
      tag_mem[fill_index] <= fill_tag;
    end
  end

  // The old line goes away with its first overwritten word.
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else if (fill.flush) begin
      valid_q <= '0;
    end else if (fill.fill_done) begin
      valid_q[fill_index] <= 1'b1;
    end else if (word_write && fill.fill_word_sel == '0) begin
      valid_q[fill_index] <= 1'b0;
    end
  end

  // Completion comes with the write of the last word of the line.
  assert property (@(posedge clock) disable iff (reset)
    fill.fill_done |-> (word_write && fill.fill_word_sel == '1))
    else $error("fill_done without the final word write");

endmodule

/* l1i_half_align.sv */
`timescale 1ns/1ns

module l1i_half_align import l1i_pkg::*; (
  input  logic  pc_half,
  input  word_t word_lo,
  input  word_t word_next,
  input  logic  hit,
  input  logic  hit_next,
  input  logic  busy_flush,
  output word_t inst,
  output logic  inst_valid
);

  half_t half_lo;
  half_t half_hi;
  logic  compressed;

  // ********************
  // Halfword select.
  // ********************

  // Low half from the word that holds pc.
  assign half_lo = pc_half ? word_lo[31:16] : word_lo[15:0];

  // Upper half crosses into the next word when pc is halfword aligned.
  assign half_hi = pc_half ? word_next[15:0] : word_lo[31:16];

  assign inst = {half_hi, half_lo};

  // ********************
  // Valid level.
  // ********************

  // RVC encodings never end in 2'b11.
  assign compressed = (half_lo[1:0] != 2'b11);

  assign inst_valid = hit && (hit_next || compressed) && !busy_flush;

endmodule

/* l1i_top.sv */
`timescale 1ns/1ns

module l1i_top import l1i_pkg::*; (
  input  logic  clock,
  input  logic  reset,

  // Fetch side.
  input  addr_t pc,
  input  logic  invalidate,
  output word_t inst,
  output logic  inst_valid,

  // Read bus.
  output addr_t araddr,
  output logic  arvalid,
  input  logic  rvalid,
  input  word_t rdata
);

  word_t word_lo;
  word_t word_next;
  logic  busy_flush;

  l1i_fill_if fill_bus ();

  l1i_fill_ctrl u_fill_ctrl (
    .clock      (clock),
    .reset      (reset),
    .pc         (pc),
    .invalidate (invalidate),
    .rvalid     (rvalid),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .busy_flush (busy_flush),
    .fill       (fill_bus.ctrl)
  );

  l1i_line_array u_line_array (
    .clock     (clock),
    .reset     (reset),
    .pc        (pc),
    .rdata     (rdata),
    .rvalid    (rvalid),
    .word_lo   (word_lo),
    .word_next (word_next),
    .fill      (fill_bus.array)
  );

  l1i_half_align u_half_align (
    .pc_half    (pc[1]),
    .word_lo    (word_lo),
    .word_next  (word_next),
    .hit        (fill_bus.hit),
    .hit_next   (fill_bus.hit_next),
    .busy_flush (busy_flush),
    .inst       (inst),
    .inst_valid (inst_valid)
  );

endmodule

/* l1i_tb.sv */
`timescale 1ns/1ns

module l1i_tb import l1i_pkg::*; ();

  localparam int CLOCK_PERIOD = 20;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_STEPS = 300;
  localparam int MAX_DELAY = 4;
  // Request cycles of both words plus the gap and the idle cycle.
  localparam int WORST_FILL_CYCLES = 2 * (MAX_DELAY + 1) + 2;
  localparam int TIMEOUT_NS = (RESET_CYCLES + NUM_STEPS * WORST_FILL_CYCLES * 2) * CLOCK_PERIOD;
  localparam logic [31:0] SEED = 32'd58151;
  localparam addr_t PC_BASE = 32'h0000_2000;
  localparam int LINE_LSB = BYTE_BITS + OFFSET_BITS;

  logic  clock;
  logic  reset;
  addr_t pc;
  logic  invalidate;
  word_t inst;
  logic  inst_valid;
  addr_t araddr;
  logic  arvalid;
  logic  rvalid;
  word_t rdata;

  // Residency model.
  logic [NUM_LINES-1:0] model_valid;
  tag_t                 model_tag [NUM_LINES];
  logic                 second_q;
  logic                 gap_q;
  logic                 arv_q;
  logic                 pend_m;
  logic                 need_req;
  logic                 in_reset_q = 1'b0;
  addr_t                fill_pc;

  addr_t  pc_next;
  addr_t  fill_pc_next;
  half_t  exp_lo;
  half_t  exp_hi;
  logic   exp_compressed;
  logic   hit_pc_m;
  logic   hit_nx_m;
  logic   busy_m;
  logic   exp_valid;
  logic   fill_start;
  index_t req_index;

  int          error_count = 0;
  int          fill_count = 0;
  int          steps_done = 0;
  logic [31:0] stim_state;
  logic [31:0] mem_state;

  l1i_top DUT (
    .clock      (clock),
    .reset      (reset),
    .pc         (pc),
    .invalidate (invalidate),
    .inst       (inst),
    .inst_valid (inst_valid),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .rvalid     (rvalid),
    .rdata      (rdata)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Each halfword is a hash of its address, ending in 2'b00 or 2'b11.
  function automatic half_t mem_half(input addr_t addr);
    logic [15:0] mix;
    logic        low_bit;
    mix     = (addr[16:1] ^ addr[31:16]) * 16'h9E37 + 16'h3C5A;
    low_bit = mix[11] ^ mix[6];
    return {mix[15:2], low_bit, low_bit};
  endfunction

  function automatic word_t mem_word(input addr_t addr);
    addr_t base;
    base = {addr[XLEN-1:BYTE_BITS], {BYTE_BITS{1'b0}}};
    return {mem_half(base + addr_t'(2)), mem_half(base)};
  endfunction

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  // ********************
  // Expected values.
  // ********************

  assign pc_next        = pc + addr_t'(2);
  assign fill_pc_next   = fill_pc + addr_t'(2);
  assign exp_lo         = mem_half(pc);
  assign exp_hi         = mem_half(pc_next);
  assign exp_compressed = (exp_lo[1:0] != 2'b11);

  assign hit_pc_m = model_valid[pc[LINE_LSB +: INDEX_BITS]] &&
                    (model_tag[pc[LINE_LSB +: INDEX_BITS]] == pc[XLEN-1 -: TAG_BITS]);
  assign hit_nx_m = model_valid[pc_next[LINE_LSB +: INDEX_BITS]] &&
                    (model_tag[pc_next[LINE_LSB +: INDEX_BITS]] == pc_next[XLEN-1 -: TAG_BITS]);

  assign busy_m     = arvalid || gap_q;
  assign fill_start = arvalid && !arv_q && !gap_q;
  assign req_index  = araddr[LINE_LSB +: INDEX_BITS];
  assign exp_valid  = hit_pc_m && (exp_compressed || hit_nx_m) && !(invalidate || pend_m);

  always @(posedge clock) begin
    in_reset_q <= reset;
    if (reset) begin
      model_valid <= '0;
      second_q    <= 1'b0;
      gap_q       <= 1'b0;
      arv_q       <= 1'b0;
      pend_m      <= 1'b0;
      need_req    <= 1'b0;
      fill_pc     <= PC_BASE;
    end else begin
      arv_q <= arvalid;
      gap_q <= rvalid && !second_q;
      // A clear requested during a fill waits for the first idle cycle.
      if (!busy_m) begin
        fill_pc <= pc;
        pend_m  <= 1'b0;
        if (invalidate || pend_m) begin
          model_valid <= '0;
        end
      end else if (invalidate) begin
        pend_m <= 1'b1;
      end
      if (rvalid) begin
        model_valid[req_index] <= second_q;
        if (second_q) begin
          model_tag[req_index] <= araddr[XLEN-1 -: TAG_BITS];
          fill_count++;
        end
        second_q <= !second_q;
      end
      if (invalidate) begin
        need_req <= 1'b1;
      end else if (fill_start) begin
        need_req <= 1'b0;
      end
    end
  end

  // ********************
  // Assertions.
  // ********************

  assert property (@(posedge clock) in_reset_q |-> (!arvalid && !inst_valid))
    else begin
      error_count++;
      $display("Error at %0t ns: arvalid or inst_valid high out of reset", $time);
    end

  assert property (@(posedge clock) disable iff (reset) inst_valid == exp_valid)
    else begin
      error_count++;
      $display("Error at %0t ns: inst_valid is %b for pc %h, expected %b", $time,
               $sampled(inst_valid), $sampled(pc), $sampled(exp_valid));
    end

  assert property (@(posedge clock) disable iff (reset) inst_valid |-> inst[15:0] == exp_lo)
    else begin
      error_count++;
      $display("Error at %0t ns: low half %h for pc %h, expected %h", $time,
               $sampled(inst[15:0]), $sampled(pc), $sampled(exp_lo));
    end

  assert property (@(posedge clock) disable iff (reset)
    (inst_valid && !exp_compressed) |-> inst[31:16] == exp_hi)
    else begin
      error_count++;
      $display("Error at %0t ns: high half %h for pc %h, expected %h", $time,
               $sampled(inst[31:16]), $sampled(pc), $sampled(exp_hi));
    end

  assert property (@(posedge clock) disable iff (reset)
    arvalid |-> (araddr[1:0] == 2'b00 && araddr[2] == second_q))
    else begin
      error_count++;
      $display("Error at %0t ns: araddr %h has the wrong word offset", $time, $sampled(araddr));
    end

  assert property (@(posedge clock) disable iff (reset)
    arvalid |-> (araddr[XLEN-1:LINE_LSB] == fill_pc[XLEN-1:LINE_LSB] ||
                 araddr[XLEN-1:LINE_LSB] == fill_pc_next[XLEN-1:LINE_LSB]))
    else begin
      error_count++;
      $display("Error at %0t ns: araddr %h is not a line of pc %h", $time,
               $sampled(araddr), $sampled(fill_pc));
    end

  assert property (@(posedge clock) disable iff (reset) inst_valid |-> !need_req)
    else begin
      error_count++;
      $display("Error at %0t ns: inst_valid after invalidate without a new read", $time);
    end

  // A fully resident pc must not start a refill.
  assert property (@(posedge clock) disable iff (reset)
    (!busy_m && hit_pc_m && hit_nx_m && !invalidate && !pend_m) |=> !arvalid)
    else begin
      error_count++;
      $display("Error at %0t ns: read request for a resident pc", $time);
    end

  // ********************
  // Memory model.
  // ********************

  initial begin
    int delay;
    rvalid    = 1'b0;
    rdata     = '0;
    mem_state = ~SEED;
    forever begin
      @(posedge clock);
      if (!reset && arvalid) begin
        mem_state = lcg_next(mem_state);
        delay = 1 + int'(mem_state[21:20]);
        repeat (delay - 1) @(posedge clock);
        rvalid <= 1'b1;
        rdata  <= mem_word(araddr);
        @(posedge clock);
        rvalid <= 1'b0;
      end
    end
  end

  // Holds pc until inst_valid, with an optional invalidate pulse on the way.
  task automatic present_pc(input addr_t new_pc, input logic do_inv, input int inv_delay);
    int   cycles;
    logic injected;
    logic done;
    pc <= new_pc;
    cycles   = 0;
    injected = !do_inv;
    done     = 1'b0;
    while (!done) begin
      @(posedge clock);
      done = inst_valid && injected;
      if (!injected && cycles == inv_delay) begin
        invalidate <= 1'b1;
        injected = 1'b1;
      end else begin
        invalidate <= 1'b0;
      end
      cycles++;
    end
  endtask

  initial begin
    addr_t history [4];
    addr_t next_pc;
    logic  do_inv;
    int    inv_delay;
    reset      = 1'b1;
    pc         = PC_BASE;
    invalidate = 1'b0;
    stim_state = SEED;
    foreach (history[i]) begin
      history[i] = PC_BASE;
    end
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    for (int step = 0; step < NUM_STEPS; step++) begin
      stim_state = lcg_next(stim_state);
      if (stim_state[31:30] == 2'b00) begin
        next_pc = history[stim_state[29:28]];
      end else begin
        next_pc = PC_BASE + addr_t'({stim_state[23:17], 1'b0});
      end
      do_inv    = (stim_state[27:25] == 3'b000);
      inv_delay = int'(stim_state[12:10]);
      present_pc(next_pc, do_inv, inv_delay);
      history[step % 4] = next_pc;
      steps_done++;
    end
    repeat (2) @(posedge clock);
    $display("Ran %0d pc steps and %0d line fills with %0d errors", steps_done, fill_count,
             error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns with %0d of %0d pc steps done", TIMEOUT_NS, steps_done,
             NUM_STEPS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* src.f */
l1i_pkg.sv
l1i_fill_if.sv
l1i_fill_ctrl.sv
l1i_line_array.sv
l1i_half_align.sv
l1i_top.sv
l1i_tb.sv

/* Bender.yml */
package:
  name: l1i_cache

sources:
  - l1i_pkg.sv
  - l1i_fill_if.sv
  - l1i_fill_ctrl.sv
  - l1i_line_array.sv
  - l1i_half_align.sv
  - l1i_top.sv
  - target: test
    files:
      - l1i_tb.sv
